//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -sv
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= dcache_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dcache_top.f
logic/dcache_pkg.sv
logic/cpu_bus_if.sv
logic/mem_bus_if.sv
logic/way_ram.sv
logic/plru_tree.sv
logic/load_align.sv
logic/dcache.sv
logic/dcache_top.sv
tests/dcache_tb.sv

//--- logic/cpu_bus_if.sv
// cpu request and load result bundle
`timescale 1ns/1ps

interface cpu_bus_if;
    logic                   valid;
    logic                   op;          // 1 = store
    dcache_pkg::addr_t      addr;
    dcache_pkg::wstrb_t     wstrb;
    dcache_pkg::word_t      wdata;
    dcache_pkg::load_type_t load_type;
    logic                   cached;
    logic                   stall;
    logic                   busy;
    dcache_pkg::word_t      rdata;

    modport cache (
        input  valid, op, addr, wstrb, wdata, load_type, cached, stall,
        output busy, rdata
    );

    modport cpu (
        output valid, op, addr, wstrb, wdata, load_type, cached, stall,
        input  busy, rdata
    );
endinterface

//--- logic/dcache.sv
// write-back set-associative data cache: lookup stage, store buffer,
// miss and uncached FSM, way arrays
`timescale 1ns/1ps

module dcache #(
    parameter int SET_NUM   = 64,
    parameter int ASSOC_NUM = 2
) (
    input logic      clk,
    input logic      rst_n,
    cpu_bus_if.cache cpu,
    mem_bus_if.cache mem
);
    localparam int IDX_BITS = $clog2(SET_NUM);
    localparam int TAG_BITS = 32 - IDX_BITS - dcache_pkg::OFFSET_BITS;
    localparam int WAY_BITS = $clog2(ASSOC_NUM);

    typedef logic [IDX_BITS-1:0]  idx_t;
    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [WAY_BITS-1:0]  way_t;
    typedef logic [ASSOC_NUM-1:0] way_vec_t;

    typedef enum logic [3:0] {
        lookup, miss_dirty, write_back, miss_clean, refill, refill_done,
        u_req, u_wait, u_done
    } state_t;

    state_t state, state_nx;

    logic                   req_valid;
    logic                   req_op;
    dcache_pkg::addr_t      req_addr;
    dcache_pkg::wstrb_t     req_wstrb;
    dcache_pkg::word_t      req_wdata;
    dcache_pkg::load_type_t req_load_type;
    logic                   req_cached;
    idx_t                   req_idx, cpu_idx;
    tag_t                   req_tag;
    logic [1:0]             req_word;

    logic              sb_valid, sb_pend;
    idx_t              sb_idx;
    tag_t              sb_tag;
    way_t              sb_way;
    dcache_pkg::line_t sb_line;
    logic              sb_match;

    tag_t              tag_out  [ASSOC_NUM];
    dcache_pkg::line_t line_out [ASSOC_NUM];
    dcache_pkg::line_t fwd_line [ASSOC_NUM];
    way_vec_t          valid_out, dirty_out, fwd_dirty, hit, way_we;
    way_t              hit_way, victim;
    logic              hit_any;

    dcache_pkg::line_t hit_line, merged, wline;
    dcache_pkg::word_t sel_word, u_rdata;
    idx_t              raddr, waddr;
    tag_t              wtag;
    logic              refill_we, cache_done, ready, collision, busy;
    logic              upd, accept, store_commit;

    assign req_idx  = req_addr[dcache_pkg::OFFSET_BITS +: IDX_BITS];
    assign req_tag  = req_addr[31 -: TAG_BITS];
    assign req_word = req_addr[dcache_pkg::OFFSET_BITS-1:2];
    assign cpu_idx  = cpu.addr[dcache_pkg::OFFSET_BITS +: IDX_BITS];
    assign sb_match = sb_valid && sb_idx == req_idx;

    assign refill_we = state == refill && mem.ret_valid;
    assign raddr     = upd ? cpu_idx : req_idx;   // re-read own set while held
    assign waddr     = refill_we ? req_idx : sb_idx;
    assign wtag      = refill_we ? req_tag : sb_tag;
    assign wline     = refill_we ? mem.ret_data : sb_line;

    for (genvar i = 0; i < ASSOC_NUM; i++) begin : g_way
        way_ram #(
            .SET_NUM  (SET_NUM),
            .TAG_BITS (TAG_BITS)
        ) u_way (
            .clk       (clk),
            .rst_n     (rst_n),
            .we_tag    (way_we[i]),
            .we_data   (way_we[i]),
            .raddr     (raddr),
            .waddr     (waddr),
            .tag_in    (wtag),
            .valid_in  (1'b1),
            .dirty_in  (!refill_we),   // store buffer writes mark dirty
            .line_in   (wline),
            .tag_out   (tag_out[i]),
            .valid_out (valid_out[i]),
            .dirty_out (dirty_out[i]),
            .line_out  (line_out[i])
        );

        assign way_we[i]    = refill_we ? victim == i : sb_pend && sb_way == i;
        assign fwd_line[i]  = (sb_match && sb_way == i) ? sb_line : line_out[i];
        assign fwd_dirty[i] = (sb_match && sb_way == i) || dirty_out[i];
        assign hit[i]       = valid_out[i] && tag_out[i] == req_tag;
    end

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < ASSOC_NUM; i++) begin
            if (hit[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    assign hit_any  = |hit;
    assign hit_line = fwd_line[hit_way];

    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req_wstrb[b]) begin
                merged[req_word*32 + b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    plru_tree #(
        .SET_NUM   (SET_NUM),
        .ASSOC_NUM (ASSOC_NUM)
    ) u_plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_idx    (req_idx),
        .access_way (refill_we ? victim : hit_way),
        .access     (refill_we || cache_done),
        .victim     (victim)
    );

    assign cache_done   = state == lookup && req_valid && req_cached && hit_any;
    assign ready        = state == u_done ||
                          (state == lookup && (!req_valid || (req_cached && hit_any)));
    assign collision    = sb_pend && cpu.valid && cpu_idx == sb_idx;
    assign busy         = !ready || collision;
    assign upd          = !busy && !cpu.stall;
    assign accept       = upd && cpu.valid;
    assign store_commit = upd && cache_done && req_op;

    assign sel_word = (state == u_done) ? u_rdata : hit_line[req_word*32 +: 32];

    load_align u_align (
        .word_in   (sel_word),
        .byte_off  (req_addr[1:0]),
        .load_type (req_load_type),
        .word_out  (cpu.rdata)
    );

    assign cpu.busy = busy;

    assign mem.rd_req   = state == miss_clean;
    assign mem.rd_addr  = {req_tag, req_idx, {dcache_pkg::OFFSET_BITS{1'b0}}};
    assign mem.wr_req   = state == miss_dirty;
    assign mem.wr_addr  = {tag_out[victim], req_idx, {dcache_pkg::OFFSET_BITS{1'b0}}};
    assign mem.wr_data  = fwd_line[victim];
    assign mem.u_rd_req = state == u_req && !req_op;
    assign mem.u_wr_req = state == u_req && req_op;
    assign mem.u_addr   = req_addr;
    assign mem.u_wdata  = req_wdata;
    assign mem.u_wstrb  = req_wstrb;

    always_comb begin
        state_nx = state;
        case (state)
            lookup: begin
                if (req_valid && !req_cached) begin
                    state_nx = u_req;
                end else if (req_valid && !hit_any) begin
                    state_nx = (valid_out[victim] && fwd_dirty[victim]) ? miss_dirty
                                                                        : miss_clean;
                end
            end
            miss_dirty: if (mem.wr_rdy) state_nx = write_back;
            write_back: if (mem.wr_done) state_nx = miss_clean;
            miss_clean: if (mem.rd_rdy) state_nx = refill;
            refill:     if (mem.ret_valid) state_nx = refill_done;
            refill_done: state_nx = lookup;   // replay against the new line
            u_req:      if (mem.u_rdy) state_nx = u_wait;
            u_wait:     if (mem.u_ret_valid || mem.u_wr_done) state_nx = u_done;
            u_done:     if (!cpu.stall) state_nx = lookup;
            default:    state_nx = lookup;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lookup;
            req_valid <= 1'b0;
            sb_valid  <= 1'b0;
            sb_pend   <= 1'b0;
        end else begin
            state   <= state_nx;
            sb_pend <= store_commit;
            if (upd) begin
                req_valid <= cpu.valid;
            end
            if (store_commit) begin
                sb_valid <= 1'b1;
            end else if (refill_we && sb_idx == req_idx && sb_way == victim) begin
                sb_valid <= 1'b0;   // line replaced under the buffer
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op        <= cpu.op;
            req_addr      <= cpu.addr;
            req_wstrb     <= cpu.wstrb;
            req_wdata     <= cpu.wdata;
            req_load_type <= cpu.load_type;
            req_cached    <= cpu.cached;
        end
        if (store_commit) begin
            sb_idx  <= req_idx;
            sb_tag  <= req_tag;
            sb_way  <= hit_way;
            sb_line <= merged;
        end
        if (mem.u_ret_valid) begin
            u_rdata <= mem.u_ret_data;
        end
    end

    a_miss_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (mem.rd_req || mem.wr_req) |-> !hit_any)
        else $error("line transfer requested for a line that already hits");

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (state == lookup && req_valid) |-> $onehot0(hit))
        else $error("tag matched in more than one way");
endmodule

//--- logic/dcache_pkg.sv
// data cache shared types: address, word, strobe and line widths
// load-type codes for the aligner
package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;

    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 4;   // byte offset inside a line

    typedef logic [LINE_WORDS*32-1:0] line_t;

    typedef logic [2:0] load_type_t;

    localparam load_type_t LOAD_W  = 3'd0;
    localparam load_type_t LOAD_H  = 3'd1;
    localparam load_type_t LOAD_HU = 3'd2;
    localparam load_type_t LOAD_B  = 3'd3;
    localparam load_type_t LOAD_BU = 3'd4;

endpackage

//--- logic/dcache_top.sv
// data cache top level with plain cpu_ and mem_ ports
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_NUM   = 64,
    parameter int ASSOC_NUM = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cpu_valid,
    input  logic                   cpu_op,
    input  dcache_pkg::addr_t      cpu_addr,
    input  dcache_pkg::wstrb_t     cpu_wstrb,
    input  dcache_pkg::word_t      cpu_wdata,
    input  dcache_pkg::load_type_t cpu_load_type,
    input  logic                   cpu_cached,
    input  logic                   cpu_stall,
    output logic                   cpu_busy,
    output dcache_pkg::word_t      cpu_rdata,
    output logic                   mem_rd_req,
    output dcache_pkg::addr_t      mem_rd_addr,
    input  logic                   mem_rd_rdy,
    input  logic                   mem_ret_valid,
    input  dcache_pkg::line_t      mem_ret_data,
    output logic                   mem_wr_req,
    output dcache_pkg::addr_t      mem_wr_addr,
    output dcache_pkg::line_t      mem_wr_data,
    input  logic                   mem_wr_rdy,
    input  logic                   mem_wr_done,
    output logic                   mem_u_rd_req,
    output logic                   mem_u_wr_req,
    output dcache_pkg::addr_t      mem_u_addr,
    output dcache_pkg::word_t      mem_u_wdata,
    output dcache_pkg::wstrb_t     mem_u_wstrb,
    input  logic                   mem_u_rdy,
    input  logic                   mem_u_ret_valid,
    input  dcache_pkg::word_t      mem_u_ret_data,
    input  logic                   mem_u_wr_done
);
    cpu_bus_if cpu_if ();
    mem_bus_if mem_if ();

    assign cpu_if.valid     = cpu_valid;
    assign cpu_if.op        = cpu_op;
    assign cpu_if.addr      = cpu_addr;
    assign cpu_if.wstrb     = cpu_wstrb;
    assign cpu_if.wdata     = cpu_wdata;
    assign cpu_if.load_type = cpu_load_type;
    assign cpu_if.cached    = cpu_cached;
    assign cpu_if.stall     = cpu_stall;
    assign cpu_busy         = cpu_if.busy;
    assign cpu_rdata        = cpu_if.rdata;

    assign mem_rd_req         = mem_if.rd_req;
    assign mem_rd_addr        = mem_if.rd_addr;
    assign mem_if.rd_rdy      = mem_rd_rdy;
    assign mem_if.ret_valid   = mem_ret_valid;
    assign mem_if.ret_data    = mem_ret_data;
    assign mem_wr_req         = mem_if.wr_req;
    assign mem_wr_addr        = mem_if.wr_addr;
    assign mem_wr_data        = mem_if.wr_data;
    assign mem_if.wr_rdy      = mem_wr_rdy;
    assign mem_if.wr_done     = mem_wr_done;
    assign mem_u_rd_req       = mem_if.u_rd_req;
    assign mem_u_wr_req       = mem_if.u_wr_req;
    assign mem_u_addr         = mem_if.u_addr;
    assign mem_u_wdata        = mem_if.u_wdata;
    assign mem_u_wstrb        = mem_if.u_wstrb;
    assign mem_if.u_rdy       = mem_u_rdy;
    assign mem_if.u_ret_valid = mem_u_ret_valid;
    assign mem_if.u_ret_data  = mem_u_ret_data;
    assign mem_if.u_wr_done   = mem_u_wr_done;

    dcache #(
        .SET_NUM   (SET_NUM),
        .ASSOC_NUM (ASSOC_NUM)
    ) u_dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .cpu   (cpu_if),
        .mem   (mem_if)
    );
endmodule

//--- logic/load_align.sv
// load data alignment: byte/halfword pick with sign or zero extension
`timescale 1ns/1ps

module load_align (
    input  dcache_pkg::word_t      word_in,
    input  logic [1:0]             byte_off,
    input  dcache_pkg::load_type_t load_type,
    output dcache_pkg::word_t      word_out
);
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word_in[byte_off*8 +: 8];
    assign half_sel = byte_off[1] ? word_in[31:16] : word_in[15:0];

    always_comb begin
        case (load_type)
            dcache_pkg::LOAD_H: begin
                word_out = {{16{half_sel[15]}}, half_sel};
            end
            dcache_pkg::LOAD_HU: begin
                word_out = {16'b0, half_sel};
            end
            dcache_pkg::LOAD_B: begin
                word_out = {{24{byte_sel[7]}}, byte_sel};
            end
            dcache_pkg::LOAD_BU: begin
                word_out = {24'b0, byte_sel};
            end
            default: begin
                word_out = word_in;   // full word
            end
        endcase
    end
endmodule

//--- logic/mem_bus_if.sv
// memory side: whole-line read/write channel and uncached word channel
`timescale 1ns/1ps

interface mem_bus_if;
    logic               rd_req;
    dcache_pkg::addr_t  rd_addr;     // line aligned
    logic               rd_rdy;
    logic               ret_valid;
    dcache_pkg::line_t  ret_data;

    logic               wr_req;
    dcache_pkg::addr_t  wr_addr;
    dcache_pkg::line_t  wr_data;
    logic               wr_rdy;
    logic               wr_done;

    logic               u_rd_req;
    logic               u_wr_req;
    dcache_pkg::addr_t  u_addr;
    dcache_pkg::word_t  u_wdata;
    dcache_pkg::wstrb_t u_wstrb;
    logic               u_rdy;
    logic               u_ret_valid;
    dcache_pkg::word_t  u_ret_data;
    logic               u_wr_done;

    modport cache (
        output rd_req, rd_addr, wr_req, wr_addr, wr_data,
        output u_rd_req, u_wr_req, u_addr, u_wdata, u_wstrb,
        input  rd_rdy, ret_valid, ret_data, wr_rdy, wr_done,
        input  u_rdy, u_ret_valid, u_ret_data, u_wr_done
    );

    modport mem (
        input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
        input  u_rd_req, u_wr_req, u_addr, u_wdata, u_wstrb,
        output rd_rdy, ret_valid, ret_data, wr_rdy, wr_done,
        output u_rdy, u_ret_valid, u_ret_data, u_wr_done
    );
endinterface

//--- logic/plru_tree.sv
// tree pseudo-LRU state per set, combinational victim
`timescale 1ns/1ps

module plru_tree #(
    parameter int SET_NUM   = 64,
    parameter int ASSOC_NUM = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [$clog2(SET_NUM)-1:0]   set_idx,
    input  logic [$clog2(ASSOC_NUM)-1:0] access_way,
    input  logic                         access,
    output logic [$clog2(ASSOC_NUM)-1:0] victim
);
    localparam int LEVELS = $clog2(ASSOC_NUM);

    // heap node n lives at bit n-1 and a set bit points right
    logic [ASSOC_NUM-2:0] tree_q [SET_NUM];
    logic [ASSOC_NUM-2:0] tree_nx;

    always_comb begin
        int node;
        node = 1;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + int'(tree_q[set_idx][node-1]);
        end
        victim = LEVELS'(node - ASSOC_NUM);
    end

    always_comb begin
        int node;
        tree_nx = tree_q[set_idx];
        node    = 1;
        for (int l = LEVELS - 1; l >= 0; l--) begin
            tree_nx[node-1] = ~access_way[l];   // point away from the used way
            node = 2 * node + int'(access_way[l]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SET_NUM; s++) begin
                tree_q[s] <= '0;
            end
        end else if (access) begin
            tree_q[set_idx] <= tree_nx;
        end
    end

    a_away_from_used: assert property (@(posedge clk) disable iff (!rst_n)
        access |=> (set_idx != $past(set_idx)) || (victim != $past(access_way)))
        else $error("plru victim still names the way just used");
endmodule

//--- logic/way_ram.sv
// one cache way: valid/dirty/tag array and line data array, synchronous read
`timescale 1ns/1ps

module way_ram #(
    parameter int SET_NUM  = 64,
    parameter int TAG_BITS = 22
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       we_tag,
    input  logic                       we_data,
    input  logic [$clog2(SET_NUM)-1:0] raddr,
    input  logic [$clog2(SET_NUM)-1:0] waddr,
    input  logic [TAG_BITS-1:0]        tag_in,
    input  logic                       valid_in,
    input  logic                       dirty_in,
    input  dcache_pkg::line_t          line_in,
    output logic [TAG_BITS-1:0]        tag_out,
    output logic                       valid_out,
    output logic                       dirty_out,
    output dcache_pkg::line_t          line_out
);
    logic [SET_NUM-1:0]  valid_q;
    logic [TAG_BITS-1:0] tag_q   [SET_NUM];
    logic                dirty_q [SET_NUM];
    dcache_pkg::line_t   line_q  [SET_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= '0;
            valid_out <= 1'b0;
        end else begin
            if (we_tag) begin
                valid_q[waddr] <= valid_in;
            end
            valid_out <= valid_q[raddr];   // old value on same-set write
        end
    end

    always_ff @(posedge clk) begin
        if (we_tag) begin
            tag_q[waddr]   <= tag_in;
            dirty_q[waddr] <= dirty_in;
        end
        if (we_data) begin
            line_q[waddr] <= line_in;
        end
        tag_out   <= tag_q[raddr];
        dirty_out <= dirty_q[raddr];
        line_out  <= line_q[raddr];
    end
endmodule

//--- tests/dcache_golden.txt
# R op addr wstrb wdata load_type cached exp_rdata stall_cycles  (hex except stall)
# M addr exp_word   checks the memory model after write-back
# load types: 0 W, 1 H, 2 HU, 3 B, 4 BU
R 0 000203e0 0 00000000 0 1 5a5a80f8 0
R 0 000203e0 0 00000000 3 1 fffffff8 0
R 0 000203e0 0 00000000 4 1 000000f8 0
R 0 000203e1 0 00000000 3 1 ffffff80 0
R 0 000203e1 0 00000000 4 1 00000080 0
R 0 000203e2 0 00000000 3 1 0000005a 0
R 0 000203e3 0 00000000 4 1 0000005a 0
R 0 000203e0 0 00000000 1 1 ffff80f8 0
R 0 000203e0 0 00000000 2 1 000080f8 0
R 0 000203e2 0 00000000 1 1 00005a5a 0
R 0 000203e2 0 00000000 2 1 00005a5a 0
# partial stores, each read back at once
R 1 00000204 3 1234abcd 0 1 00000000 0
R 0 00000204 0 00000000 0 1 5a5aabcd 0
R 1 00000204 c dead0000 0 1 00000000 0
R 0 00000204 0 00000000 0 1 deadabcd 0
R 1 00000208 2 00007700 0 1 00000000 0
R 0 00000209 0 00000000 4 1 00000077 0
# three lines in set 0x20 force dirty evictions
R 1 00000600 f cafef00d 0 1 00000000 0
R 0 00000a00 0 00000000 0 1 5a5a0280 0
M 00000204 deadabcd
M 00000208 5a5a7782
R 0 00000204 0 00000000 0 1 deadabcd 0
M 00000600 cafef00d
# uncached word channel, stall in done state
R 1 00008000 f 13572468 0 0 00000000 0
R 0 00008000 0 00000000 0 0 13572468 3
R 0 00008001 0 00000000 4 0 00000024 0
# stall on a cached hit result
R 0 000203e0 0 00000000 0 1 5a5a80f8 4

//--- tests/dcache_tb.sv
// data cache testbench: clock, reset, memory model with random delays,
// golden-file request driver and compare tasks
`timescale 1ns/1ps

module dcache_tb;
    localparam int TIMEOUT = 200;

    logic clk, rst_n;
    logic cpu_valid, cpu_op, cpu_cached, cpu_stall, cpu_busy;
    dcache_pkg::addr_t cpu_addr, mem_rd_addr, mem_wr_addr, mem_u_addr;
    dcache_pkg::wstrb_t cpu_wstrb, mem_u_wstrb;
    dcache_pkg::word_t cpu_wdata, cpu_rdata, mem_u_wdata, mem_u_ret_data;
    dcache_pkg::load_type_t cpu_load_type;
    dcache_pkg::line_t mem_ret_data, mem_wr_data;
    logic mem_rd_req, mem_rd_rdy, mem_ret_valid, mem_wr_req, mem_wr_rdy, mem_wr_done;
    logic mem_u_rd_req, mem_u_wr_req, mem_u_rdy, mem_u_ret_valid, mem_u_wr_done;

    logic [31:0] lfsr;
    dcache_pkg::word_t mem_q [int unsigned];   // what the DUT wrote
    dcache_pkg::word_t ref_q [int unsigned];   // stores as issued
    int errors, line_ops;
    logic timed_out;

    dcache_top #(.SET_NUM(64), .ASSOC_NUM(2)) dut (.*);

    always #4 clk = ~clk;

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic int rand_delay();
        int d;
        d = int'(next_bit());
        d = d * 2 + int'(next_bit());
        return d;
    endfunction

    function automatic dcache_pkg::word_t model_word(int unsigned wa, logic from_ref);
        if (from_ref && ref_q.exists(wa)) return ref_q[wa];
        if (!from_ref && mem_q.exists(wa)) return mem_q[wa];
        return wa ^ 32'h5a5a0000;   // untouched memory
    endfunction

    function automatic dcache_pkg::word_t merge(dcache_pkg::word_t old,
                                                dcache_pkg::wstrb_t ws, dcache_pkg::word_t wd);
        for (int b = 0; b < 4; b++) begin
            if (ws[b]) old[b*8 +: 8] = wd[b*8 +: 8];
        end
        return old;
    endfunction

    task automatic check_word(string name, dcache_pkg::word_t got, dcache_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(string name, dcache_pkg::line_t got, dcache_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic serve_line_read();
        dcache_pkg::line_t l;
        int unsigned wa;
        wa = mem_rd_addr >> 2;
        line_ops++;
        for (int i = 0; i < dcache_pkg::LINE_WORDS; i++) l[i*32 +: 32] = model_word(wa + i, 0);
        repeat (rand_delay() + 1) @(posedge clk);
        mem_rd_rdy <= 1'b1;
        @(posedge clk);
        mem_rd_rdy <= 1'b0;
        repeat (rand_delay()) @(posedge clk);
        mem_ret_valid <= 1'b1;
        mem_ret_data  <= l;
        @(posedge clk);
        mem_ret_valid <= 1'b0;
    endtask

    task automatic serve_line_write();
        dcache_pkg::line_t exp;
        int unsigned wa;
        wa = mem_wr_addr >> 2;
        line_ops++;
        for (int i = 0; i < dcache_pkg::LINE_WORDS; i++) begin
            exp[i*32 +: 32] = model_word(wa + i, 1);
            mem_q[wa + i]   = mem_wr_data[i*32 +: 32];
        end
        check_line("mem_wr_data", mem_wr_data, exp);
        repeat (rand_delay() + 1) @(posedge clk);
        mem_wr_rdy <= 1'b1;
        @(posedge clk);
        mem_wr_rdy <= 1'b0;
        repeat (rand_delay()) @(posedge clk);
        mem_wr_done <= 1'b1;
        @(posedge clk);
        mem_wr_done <= 1'b0;
    endtask

    task automatic serve_uncached();
        logic is_wr;
        int unsigned wa;
        is_wr = mem_u_wr_req;
        wa = mem_u_addr >> 2;
        if (is_wr) mem_q[wa] = merge(model_word(wa, 0), mem_u_wstrb, mem_u_wdata);
        repeat (rand_delay() + 1) @(posedge clk);
        mem_u_rdy <= 1'b1;
        @(posedge clk);
        mem_u_rdy <= 1'b0;
        repeat (rand_delay()) @(posedge clk);
        mem_u_wr_done   <= is_wr;
        mem_u_ret_valid <= !is_wr;
        mem_u_ret_data  <= model_word(wa, 0);
        @(posedge clk);
        mem_u_wr_done   <= 1'b0;
        mem_u_ret_valid <= 1'b0;
    endtask

    // memory model samples requests mid-cycle
    always begin
        @(negedge clk);
        if (rst_n && mem_rd_req) serve_line_read();
        else if (rst_n && mem_wr_req) serve_line_write();
        else if (rst_n && (mem_u_rd_req || mem_u_wr_req)) serve_uncached();
    end

    task automatic wait_not_busy(string what);
        int t;
        t = 0;
        @(negedge clk);
        while (cpu_busy && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (cpu_busy) begin
            $display("timeout: cache stayed busy while waiting for %s", what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_request(logic op, dcache_pkg::addr_t addr, dcache_pkg::wstrb_t ws,
                               dcache_pkg::word_t wd, dcache_pkg::load_type_t lt,
                               logic cached, dcache_pkg::word_t exp, int stall);
        int ops0;
        ops0 = line_ops;
        @(posedge clk);
        cpu_valid     <= 1'b1;
        cpu_op        <= op;
        cpu_addr      <= addr;
        cpu_wstrb     <= ws;
        cpu_wdata     <= wd;
        cpu_load_type <= lt;
        cpu_cached    <= cached;
        wait_not_busy("acceptance");
        if (timed_out) return;
        @(posedge clk);
        cpu_stall <= stall > 0;   // hold the result cycle
        if (stall > 0) begin
            cpu_addr <= addr ^ 32'h4;   // another word that must not be taken
        end else begin
            cpu_valid <= 1'b0;
        end
        if (op) ref_q[addr >> 2] = merge(model_word(addr >> 2, 1), ws, wd);
        wait_not_busy("the result");
        if (timed_out) return;
        for (int k = 0; k < stall; k++) begin
            if (!op) check_word("cpu_rdata", cpu_rdata, exp);
            @(negedge clk);
        end
        if (stall > 0) begin
            @(posedge clk);
            cpu_stall <= 1'b0;
            cpu_valid <= 1'b0;
            @(negedge clk);
        end
        if (!op) check_word("cpu_rdata", cpu_rdata, exp);
        if (!cached && line_ops != ops0) begin
            $display("uncached request at %h used the line channel", addr);
            errors++;
        end
    endtask

    initial begin
        int fd, n, tests, err0;
        string tok, rest;
        dcache_pkg::word_t f_op, f_addr, f_ws, f_wd, f_lt, f_cached, f_exp;
        int f_stall;
        clk = 1'b0;
        rst_n = 1'b0;
        lfsr = 32'hbd04;
        errors = 0;
        tests = 0;
        line_ops = 0;
        timed_out = 1'b0;
        {cpu_valid, cpu_op, cpu_cached, cpu_stall} = '0;
        cpu_addr = '0;
        cpu_wstrb = '0;
        cpu_wdata = '0;
        cpu_load_type = '0;
        {mem_rd_rdy, mem_ret_valid, mem_wr_rdy, mem_wr_done} = '0;
        {mem_u_rdy, mem_u_ret_valid, mem_u_wr_done} = '0;
        mem_ret_data = '0;
        mem_u_ret_data = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("tests/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", tok) == 1) begin
                err0 = errors;
                if (tok == "R") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %d", f_op, f_addr, f_ws, f_wd,
                                f_lt, f_cached, f_exp, f_stall);
                    if (n != 8) begin
                        $display("golden file request line is malformed");
                        errors++;
                    end
                    run_request(f_op[0], f_addr, f_ws[3:0], f_wd, f_lt[2:0], f_cached[0],
                                f_exp, f_stall);
                end else if (tok == "M") begin
                    n = $fscanf(fd, "%h %h", f_addr, f_exp);
                    if (n != 2) begin
                        $display("golden file memory line is malformed");
                        errors++;
                    end
                    check_word($sformatf("mem[%h]", f_addr), model_word(f_addr >> 2, 0), f_exp);
                end else begin
                    n = $fgets(rest, fd);   // comment line
                    continue;
                end
                tests++;
                $display("test %0d %s %h: %s", tests, tok, f_addr,
                         (errors == err0) ? "ok" : "FAIL");
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule
